/* hdl/gfx_video_pkg.sv */
`default_nettype none

package gfx_video_pkg;

    // layer fetchers sharing VRAM port B
    localparam int NUM_LAYERS = 2;

    // read slots per round, slots past NUM_LAYERS stay idle
    localparam int NUM_SLOTS = 4;
    localparam int SLOT_W = $clog2(NUM_SLOTS);

    // VRAM is 4K words, split in four 1K banks
    localparam int VRAM_DEPTH = 4096;

    typedef logic [11:0] vram_addr_t;
    typedef logic [15:0] vram_word_t;

    // hdump and vdump counters
    typedef logic [8:0] beam_t;

    typedef logic [7:0] color_t;
    typedef logic [7:0] scroll_t;

    typedef struct packed {
        logic                     video_en;
        logic                     flip;
        logic                     page;
        scroll_t [NUM_LAYERS-1:0] scroll_x;
    } gfx_cfg_t;

    // color 0 is transparent
    typedef struct packed {
        color_t color;
        logic   layer;
    } layer_pxl_t;

endpackage

`default_nettype wire

/* hdl/gfx_cpu_pkg.sv */
`default_nettype none

package gfx_cpu_pkg;

    typedef logic [12:0] cpu_addr_t;
    typedef logic [7:0]  cpu_byte_t;

    // VRAM bank and word offset inside a bank
    typedef logic [1:0] bank_t;
    typedef logic [9:0] dma_off_t;

    // configuration register indices, addr[1:0]
    localparam logic [1:0] REG_CTRL    = 2'd0;
    localparam logic [1:0] REG_SCROLL0 = 2'd1;
    localparam logic [1:0] REG_SCROLL1 = 2'd2;
    localparam logic [1:0] REG_DMA     = 2'd3;

    // single-cycle strobe request
    typedef struct packed {
        logic      vram_cs;
        logic      cfg_cs;
        logic      we;
        cpu_addr_t addr;
        cpu_byte_t data;
    } cpu_req_t;

    typedef struct packed {
        logic  start;
        bank_t src_bank;
        bank_t dst_bank;
    } dma_cmd_t;

endpackage

`default_nettype wire

/* hdl/gfx_dual_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module gfx_dual_ram
    import gfx_video_pkg::*;
(
    input  wire             clk,
    input  wire vram_addr_t a_addr,
    input  wire vram_word_t a_data,
    input  wire [1:0]       a_we,
    output vram_word_t      a_q,
    input  wire vram_addr_t b_addr,
    output vram_word_t      b_q
);

    vram_word_t mem [0:VRAM_DEPTH-1];

    // port A, written lanes show up on q right away
    always_ff @(posedge clk) begin
        if (a_we[0]) begin
            mem[a_addr][7:0] <= a_data[7:0];
        end
        if (a_we[1]) begin
            mem[a_addr][15:8] <= a_data[15:8];
        end
        a_q[7:0]  <= a_we[0] ? a_data[7:0] : mem[a_addr][7:0];
        a_q[15:8] <= a_we[1] ? a_data[15:8] : mem[a_addr][15:8];
    end

    // port B, video reads only
    always_ff @(posedge clk) begin
        b_q <= mem[b_addr];
    end

endmodule

`default_nettype wire

/* hdl/gfx_cpu_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module gfx_cpu_regs
    import gfx_video_pkg::*;
    import gfx_cpu_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire cpu_req_t   req,
    input  wire vram_word_t vram_q,
    input  wire             dma_busy,
    output gfx_cfg_t        cfg,
    output dma_cmd_t        dma_cmd,
    output cpu_byte_t       cpu_din
);

    logic      rd_vram;
    logic      rd_hi;
    cpu_byte_t rd_reg;
    cpu_byte_t reg_val;

    // register value at the requested index
    always_comb begin
        case (req.addr[1:0])
            REG_CTRL:    reg_val = {5'b0, cfg.page, cfg.flip, cfg.video_en};
            REG_SCROLL0: reg_val = cfg.scroll_x[0];
            REG_SCROLL1: reg_val = cfg.scroll_x[1];
            default:     reg_val = {7'b0, dma_busy};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg     <= '0;
            dma_cmd <= '0;
            rd_vram <= 1'b0;
            rd_hi   <= 1'b0;
            rd_reg  <= '0;
        end else begin
            dma_cmd.start <= 1'b0;
            rd_vram       <= req.vram_cs & ~req.we;
            rd_hi         <= req.addr[12];
            rd_reg        <= '0;
            if (req.cfg_cs && req.we) begin
                case (req.addr[1:0])
                    REG_CTRL: begin
                        cfg.video_en <= req.data[0];
                        cfg.flip     <= req.data[1];
                        cfg.page     <= req.data[2];
                    end
                    REG_SCROLL0: cfg.scroll_x[0] <= req.data;
                    REG_SCROLL1: cfg.scroll_x[1] <= req.data;
                    default: begin
                        // DMA engine drops this if it is already running
                        dma_cmd.start    <= 1'b1;
                        dma_cmd.src_bank <= req.data[1:0];
                        dma_cmd.dst_bank <= req.data[3:2];
                    end
                endcase
            end
            if (req.cfg_cs && !req.we) begin
                rd_reg <= reg_val;
            end
        end
    end

    // VRAM word arrives one clock after the strobe
    assign cpu_din = rd_vram ? (rd_hi ? vram_q[15:8] : vram_q[7:0]) : rd_reg;

endmodule

`default_nettype wire

/* hdl/gfx_vram_dma.sv */
`timescale 1ns/10ps
`default_nettype none

module gfx_vram_dma
    import gfx_video_pkg::*;
    import gfx_cpu_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire cpu_req_t   req,
    input  wire dma_cmd_t   dma_cmd,
    input  wire vram_word_t ram_q,
    output vram_addr_t      ram_addr,
    output vram_word_t      ram_data,
    output logic [1:0]      ram_we,
    output logic            dma_busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } dma_state_t;

    dma_state_t state;
    bank_t      src_bank;
    bank_t      dst_bank;
    dma_off_t   word_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            src_bank <= '0;
            dst_bank <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (dma_cmd.start) begin
                        src_bank <= dma_cmd.src_bank;
                        dst_bank <= dma_cmd.dst_bank;
                        word_cnt <= '0;
                        state    <= ST_READ;
                    end
                end
                ST_READ: state <= ST_WRITE;
                ST_WRITE: begin
                    word_cnt <= word_cnt + 1'b1;
                    // last offset done after 1024 read/write pairs
                    state    <= (word_cnt == '1) ? ST_IDLE : ST_READ;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        // idle: CPU owns port A, byte copied to both lanes
        ram_addr = req.addr[11:0];
        ram_data = {2{req.data}};
        ram_we   = {2{req.vram_cs & req.we}} & {req.addr[12], ~req.addr[12]};
        case (state)
            ST_READ: begin
                ram_addr = {src_bank, word_cnt};
                ram_we   = 2'b00;
            end
            ST_WRITE: begin
                // source word read in the previous cycle
                ram_addr = {dst_bank, word_cnt};
                ram_data = ram_q;
                ram_we   = 2'b11;
            end
            default: ;
        endcase
    end

    assign dma_busy = (state != ST_IDLE);

endmodule

`default_nettype wire

/* hdl/gfx_slot_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module gfx_slot_seq
    import gfx_video_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire vram_addr_t      fetch_addr [NUM_LAYERS],
    input  wire vram_word_t      ram_q,
    output vram_addr_t           ram_addr,
    output logic [NUM_LAYERS-1:0] rd_valid,
    output vram_word_t           rd_word
);

    logic [SLOT_W-1:0]     slot_cnt;
    logic [NUM_LAYERS-1:0] slot_hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_cnt <= '0;
        end else if (slot_cnt == SLOT_W'(NUM_SLOTS - 1)) begin
            slot_cnt <= '0;
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    // owner of the current slot, none past NUM_LAYERS
    always_comb begin
        ram_addr = '0;
        slot_hit = '0;
        for (int k = 0; k < NUM_LAYERS; k++) begin
            if (slot_cnt == SLOT_W'(k)) begin
                ram_addr    = fetch_addr[k];
                slot_hit[k] = 1'b1;
            end
        end
    end

    // RAM answers one clock later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= '0;
        end else begin
            rd_valid <= slot_hit;
        end
    end

    assign rd_word = ram_q;

endmodule

`default_nettype wire

/* hdl/gfx_layer_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module gfx_layer_fetch
    import gfx_video_pkg::*;
#(
    parameter int LAYER = 0
) (
    input  wire             clk,
    input  wire             rst,
    input  wire gfx_cfg_t   cfg,
    input  wire beam_t      hdump,
    input  wire beam_t      vdump,
    output vram_addr_t      rd_addr,
    input  wire             rd_valid,
    input  wire vram_word_t rd_word,
    output color_t          color
);

    logic [7:0] eff_x;
    logic [7:0] scr_x;

    // mirrored column when the screen is flipped
    assign eff_x = cfg.flip ? (8'd255 - hdump[7:0]) : hdump[7:0];

    // wraps at 256
    assign scr_x = eff_x + cfg.scroll_x[LAYER];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_addr <= '0;
        end else begin
            // page, layer bank, tile row, tile column
            rd_addr <= {cfg.page, 1'(LAYER), vdump[7:3], scr_x[7:3]};
        end
    end

    // low byte of the tile word is the pixel color
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            color <= '0;
        end else if (rd_valid) begin
            color <= rd_word[7:0];
        end
    end

endmodule

`default_nettype wire

/* hdl/gfx_layer_mix.sv */
`timescale 1ns/10ps
`default_nettype none

module gfx_layer_mix
    import gfx_video_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire gfx_cfg_t cfg,
    input  wire color_t   colors [NUM_LAYERS],
    output layer_pxl_t    pix
);

    layer_pxl_t top_pxl;

    // lowest opaque layer wins, last layer shows through otherwise
    always_comb begin
        top_pxl.color = colors[NUM_LAYERS-1];
        top_pxl.layer = 1'(NUM_LAYERS - 1);
        for (int k = NUM_LAYERS - 2; k >= 0; k--) begin
            if (colors[k] != '0) begin
                top_pxl.color = colors[k];
                top_pxl.layer = 1'(k);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix <= '0;
        end else begin
            pix <= cfg.video_en ? top_pxl : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/gfx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module gfx_top
    import gfx_video_pkg::*;
    import gfx_cpu_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire cpu_req_t req,
    input  wire beam_t    hdump,
    input  wire beam_t    vdump,
    output cpu_byte_t     cpu_din,
    output logic          dma_busy,
    output layer_pxl_t    pix
);

    gfx_cfg_t              cfg;
    dma_cmd_t              dma_cmd;
    vram_addr_t            a_addr;
    vram_word_t            a_data;
    logic [1:0]            a_we;
    vram_word_t            a_q;
    vram_addr_t            b_addr;
    vram_word_t            b_q;
    vram_addr_t            fetch_addr [NUM_LAYERS];
    logic [NUM_LAYERS-1:0] rd_valid;
    vram_word_t            rd_word;
    color_t                colors [NUM_LAYERS];

    gfx_cpu_regs cpu_regs_inst (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .vram_q   (a_q),
        .dma_busy (dma_busy),
        .cfg      (cfg),
        .dma_cmd  (dma_cmd),
        .cpu_din  (cpu_din)
    );

    gfx_vram_dma vram_dma_inst (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .dma_cmd  (dma_cmd),
        .ram_q    (a_q),
        .ram_addr (a_addr),
        .ram_data (a_data),
        .ram_we   (a_we),
        .dma_busy (dma_busy)
    );

    gfx_dual_ram dual_ram_inst (
        .clk    (clk),
        .a_addr (a_addr),
        .a_data (a_data),
        .a_we   (a_we),
        .a_q    (a_q),
        .b_addr (b_addr),
        .b_q    (b_q)
    );

    gfx_slot_seq slot_seq_inst (
        .clk        (clk),
        .rst        (rst),
        .fetch_addr (fetch_addr),
        .ram_q      (b_q),
        .ram_addr   (b_addr),
        .rd_valid   (rd_valid),
        .rd_word    (rd_word)
    );

    // one fetcher per tile layer
    for (genvar i = 0; i < NUM_LAYERS; i++) begin : g_layer
        gfx_layer_fetch #(
            .LAYER (i)
        ) layer_fetch_inst (
            .clk      (clk),
            .rst      (rst),
            .cfg      (cfg),
            .hdump    (hdump),
            .vdump    (vdump),
            .rd_addr  (fetch_addr[i]),
            .rd_valid (rd_valid[i]),
            .rd_word  (rd_word),
            .color    (colors[i])
        );
    end

    gfx_layer_mix layer_mix_inst (
        .clk    (clk),
        .rst    (rst),
        .cfg    (cfg),
        .colors (colors),
        .pix    (pix)
    );

endmodule

`default_nettype wire

/* verif/gfx_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module gfx_tb
    import gfx_video_pkg::*;
    import gfx_cpu_pkg::*;
();

    localparam int MAX_CYCLES = 12000;
    localparam int HOLD_CLKS  = 12;
    localparam int DMA_CYCLES = 2048;

    logic       clk;
    logic       rst;
    cpu_req_t   req;
    beam_t      hdump;
    beam_t      vdump;
    cpu_byte_t  cpu_din;
    logic       dma_busy;
    layer_pxl_t pix;

    // reference copies of VRAM and the configuration registers
    vram_word_t vram_m [VRAM_DEPTH];
    logic       en_m;
    logic       flip_m;
    logic       page_m;
    scroll_t    scroll_m [NUM_LAYERS];

    logic [31:0] rng_state = 32'd55305;
    int          cycles = 0;
    int          test_errs = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    gfx_top gfx_top_inst (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .hdump    (hdump),
        .vdump    (vdump),
        .cpu_din  (cpu_din),
        .dma_busy (dma_busy),
        .pix      (pix)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit in clock cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a test never completed", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic cpu_req_t make_req(input logic vram_cs, input logic we,
                                          input cpu_addr_t addr, input cpu_byte_t data);
        cpu_req_t r;
        r.vram_cs = vram_cs;
        r.cfg_cs  = ~vram_cs;
        r.we      = we;
        r.addr    = addr;
        r.data    = data;
        return r;
    endfunction

    function automatic cpu_addr_t reg_addr(input logic [1:0] idx);
        return {11'd0, idx};
    endfunction

    // word a fetcher should read for this beam position
    function automatic vram_addr_t tile_addr(input int layer, input beam_t h, input beam_t v);
        logic [7:0] eff_x;
        logic [7:0] scr_x;
        eff_x = flip_m ? (8'd255 - h[7:0]) : h[7:0];
        scr_x = eff_x + scroll_m[layer];
        return {page_m, layer[0], v[7:3], scr_x[7:3]};
    endfunction

    function automatic layer_pxl_t expected_pix(input beam_t h, input beam_t v);
        color_t     c0;
        color_t     c1;
        layer_pxl_t p;
        c0 = vram_m[tile_addr(0, h, v)][7:0];
        c1 = vram_m[tile_addr(1, h, v)][7:0];
        p = '0;
        if (en_m) begin
            p.color = (c0 != 8'd0) ? c0 : c1;
            p.layer = (c0 != 8'd0) ? 1'b0 : 1'b1;
        end
        return p;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        test_errs++;
    endtask

    task automatic report_fault(input string msg);
        $display("failure at %0t: %s", $time, msg);
        test_errs++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, test_errs);
            tests_failed++;
        end
        errors += test_errs;
        test_errs = 0;
    endtask

    task automatic cpu_write(input logic vram_cs, input cpu_addr_t addr, input cpu_byte_t data);
        @(posedge clk);
        req <= make_req(vram_cs, 1'b1, addr, data);
    endtask

    task automatic bus_idle();
        @(posedge clk);
        req <= '0;
    endtask

    // data comes back on the clock after the strobe
    task automatic cpu_read(input logic vram_cs, input cpu_addr_t addr, output cpu_byte_t data);
        @(posedge clk);
        req <= make_req(vram_cs, 1'b0, addr, 8'h00);
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        data = cpu_din;
    endtask

    task automatic vram_write_byte(input vram_addr_t a, input logic hi, input cpu_byte_t data);
        cpu_write(1'b1, {hi, a}, data);
        if (hi) begin
            vram_m[a][15:8] = data;
        end else begin
            vram_m[a][7:0] = data;
        end
    endtask

    task automatic check_vram_byte(input vram_addr_t a, input logic hi);
        cpu_byte_t d;
        cpu_byte_t exp;
        cpu_read(1'b1, {hi, a}, d);
        exp = hi ? vram_m[a][15:8] : vram_m[a][7:0];
        if (d !== exp) report_value("cpu_din", d, exp);
    endtask

    // back-to-back reads of every byte in a bank
    task automatic check_bank(input bank_t bank);
        vram_addr_t a;
        cpu_byte_t  exp;
        int         k;
        for (int j = 0; j <= 2048; j++) begin
            @(posedge clk);
            if (j < 2048) begin
                req <= make_req(1'b1, 1'b0, {j[0], bank, 10'(j >> 1)}, 8'h00);
            end else begin
                req <= '0;
            end
            @(negedge clk);
            if (j > 0) begin
                k = j - 1;
                a = {bank, 10'(k >> 1)};
                exp = k[0] ? vram_m[a][15:8] : vram_m[a][7:0];
                if (cpu_din !== exp) report_value("cpu_din", cpu_din, exp);
            end
        end
    endtask

    task automatic set_ctrl(input cpu_byte_t val);
        cpu_write(1'b0, reg_addr(REG_CTRL), val);
        en_m   = val[0];
        flip_m = val[1];
        page_m = val[2];
    endtask

    task automatic set_scroll(input int l, input scroll_t val);
        cpu_write(1'b0, reg_addr((l == 0) ? REG_SCROLL0 : REG_SCROLL1), val);
        scroll_m[l] = val;
    endtask

    task automatic hold_and_check_pixel(input beam_t h, input beam_t v);
        layer_pxl_t exp;
        bus_idle();
        hdump <= h;
        vdump <= v;
        repeat (HOLD_CLKS) @(posedge clk);
        @(negedge clk);
        exp = expected_pix(h, v);
        if (pix !== exp) report_value("pix", pix, exp);
    endtask

    task automatic test_reset_state();
        cpu_byte_t d;
        if (pix !== '0) report_value("pix", pix, 0);
        if (dma_busy !== 1'b0) report_value("dma_busy", dma_busy, 0);
        for (int r = 0; r < 4; r++) begin
            cpu_read(1'b0, reg_addr(2'(r)), d);
            if (d !== 8'h00) report_value("cpu_din", d, 0);
        end
        finish_test("reset_state");
    endtask

    task automatic test_registers();
        cpu_byte_t d;
        cpu_byte_t ctrl;
        scroll_t   s0;
        scroll_t   s1;
        ctrl = 8'(next_rand());
        s0 = 8'(next_rand());
        s1 = 8'(next_rand());
        set_ctrl(ctrl);
        set_scroll(0, s0);
        set_scroll(1, s1);
        cpu_read(1'b0, reg_addr(REG_CTRL), d);
        if (d !== {5'b0, ctrl[2:0]}) report_value("cpu_din", d, {5'b0, ctrl[2:0]});
        cpu_read(1'b0, reg_addr(REG_SCROLL0), d);
        if (d !== s0) report_value("cpu_din", d, s0);
        cpu_read(1'b0, reg_addr(REG_SCROLL1), d);
        if (d !== s1) report_value("cpu_din", d, s1);
        // busy flag reads 0 with no copy running
        cpu_read(1'b0, reg_addr(REG_DMA), d);
        if (d !== 8'h00) report_value("cpu_din", d, 0);
        finish_test("registers");
    endtask

    task automatic test_vram_bytes();
        vram_addr_t a;
        for (int i = 0; i < 8; i++) begin
            a = 12'(next_rand());
            vram_write_byte(a, 1'b0, 8'(next_rand()));
            vram_write_byte(a, 1'b1, 8'(next_rand()));
            check_vram_byte(a, 1'b0);
            check_vram_byte(a, 1'b1);
            // rewrite the low lane and check the high lane kept its byte
            vram_write_byte(a, 1'b0, 8'(next_rand()));
            check_vram_byte(a, 1'b1);
            check_vram_byte(a, 1'b0);
        end
        finish_test("vram_bytes");
    endtask

    task automatic test_layer_mix();
        beam_t  h;
        beam_t  v;
        color_t c0;
        color_t c1;
        for (int pg = 0; pg < 2; pg++) begin
            set_ctrl({5'b0, pg[0], 1'b0, 1'b1});
            set_scroll(0, 8'h00);
            set_scroll(1, 8'h00);
            // layer 0 opaque, layer 0 clear, both clear
            for (int k = 0; k < 3; k++) begin
                h = 9'(next_rand());
                v = 9'(next_rand());
                c0 = (k == 0) ? (8'(next_rand()) | 8'h01) : 8'h00;
                c1 = (k == 2) ? 8'h00 : (8'(next_rand()) | 8'h01);
                vram_write_byte(tile_addr(0, h, v), 1'b0, c0);
                vram_write_byte(tile_addr(1, h, v), 1'b0, c1);
                hold_and_check_pixel(h, v);
            end
        end
        set_ctrl(8'h00);
        hold_and_check_pixel(h, v);
        finish_test("layer_mix");
    endtask

    task automatic test_scroll_flip();
        beam_t  v;
        color_t c;
        v = 9'(next_rand());
        set_ctrl(8'h05);
        // one full tile row on both layers
        for (int l = 0; l < NUM_LAYERS; l++) begin
            for (int col = 0; col < 32; col++) begin
                c = 8'(next_rand());
                if (c[7:5] == 3'd0) c = 8'h00;
                vram_write_byte({page_m, l[0], v[7:3], col[4:0]}, 1'b0, c);
            end
        end
        for (int i = 0; i < 16; i++) begin
            set_ctrl({5'b0, 1'b1, i[0], 1'b1});
            set_scroll(0, 8'(next_rand()));
            set_scroll(1, 8'(next_rand()));
            hold_and_check_pixel(9'(next_rand()), v);
        end
        finish_test("scroll_flip");
    endtask

    task automatic test_dma();
        bank_t      src;
        bank_t      dst;
        vram_addr_t probe;
        vram_word_t w;
        int         busy_len;
        src = 2'd1;
        dst = 2'd2;
        for (int i = 0; i < 1024; i++) begin
            w = 16'(next_rand());
            vram_write_byte({src, 10'(i)}, 1'b0, w[7:0]);
            vram_write_byte({src, 10'(i)}, 1'b1, w[15:8]);
        end
        probe = {2'd0, 10'(next_rand())};
        vram_write_byte(probe, 1'b0, 8'(next_rand()));
        vram_write_byte(probe, 1'b1, 8'(next_rand()));
        cpu_write(1'b0, reg_addr(REG_DMA), {4'b0, dst, src});
        bus_idle();
        @(negedge clk);
        if (dma_busy !== 1'b0) report_fault("dma_busy rose on the command clock");
        @(negedge clk);
        if (dma_busy !== 1'b1) report_fault("dma_busy did not rise one clock after the command");
        // a CPU write, a second command and a status read while the copy runs
        busy_len = 0;
        while (dma_busy === 1'b1 && busy_len < 2 * DMA_CYCLES) begin
            busy_len++;
            @(posedge clk);
            if (busy_len == 100) begin
                req <= make_req(1'b1, 1'b1, {1'b0, probe}, ~vram_m[probe][7:0]);
            end else if (busy_len == 101) begin
                req <= make_req(1'b0, 1'b1, reg_addr(REG_DMA), {4'b0, 2'd0, 2'd3});
            end else if (busy_len == 102) begin
                req <= '0;
            end else if (busy_len == 200) begin
                req <= make_req(1'b0, 1'b0, reg_addr(REG_DMA), 8'h00);
            end else if (busy_len == 201) begin
                req <= '0;
            end
            @(negedge clk);
            // status register shows the busy flag mid-copy
            if (busy_len == 201 && cpu_din !== 8'h01) begin
                report_value("cpu_din", cpu_din, 8'h01);
            end
        end
        if (busy_len != DMA_CYCLES) report_value("dma_busy length", busy_len, DMA_CYCLES);
        for (int i = 0; i < 1024; i++) begin
            vram_m[{dst, 10'(i)}] = vram_m[{src, 10'(i)}];
        end
        check_bank(dst);
        check_vram_byte(probe, 1'b0);
        check_vram_byte(probe, 1'b1);
        finish_test("dma_copy");
    endtask

    initial begin
        rst = 1'b1;
        req = '0;
        hdump = '0;
        vdump = '0;
        en_m = 1'b0;
        flip_m = 1'b0;
        page_m = 1'b0;
        scroll_m[0] = '0;
        scroll_m[1] = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        test_reset_state();
        test_registers();
        test_vram_bytes();
        test_layer_mix();
        test_scroll_flip();
        test_dma();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* gfx_top.f */
hdl/gfx_video_pkg.sv
hdl/gfx_cpu_pkg.sv
hdl/gfx_dual_ram.sv
hdl/gfx_cpu_regs.sv
hdl/gfx_vram_dma.sv
hdl/gfx_slot_seq.sv
hdl/gfx_layer_fetch.sv
hdl/gfx_layer_mix.sv
hdl/gfx_top.sv
verif/gfx_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f gfx_top.f \
    --top-module gfx_tb \
    -o gfx_sim

./obj_dir/gfx_sim | tee sim.log

grep -q "Test OK" sim.log
echo "simulation passed"
